//--- hdl/chip_pkg.sv
`default_nettype none

package chip_pkg;

  // GPIO pin count
  localparam int GPIO_W = 12;

  // APB request, psel travels separately per slave
  typedef struct packed {
    logic [7:0]  paddr;
    logic        pwrite;
    logic        penable;
    logic [31:0] pwdata;
  } apb_req_t;

  typedef struct packed {
    logic [31:0] prdata;
  } apb_rsp_t;

  // DMI op field, BUSY only appears in capture
  typedef enum logic [1:0] {
    DMI_NOP   = 2'd0,
    DMI_READ  = 2'd1,
    DMI_WRITE = 2'd2,
    DMI_BUSY  = 2'd3
  } dmi_op_e;

  // Command crossing from TCK into the system clock
  typedef struct packed {
    logic [7:0]  addr;
    logic [31:0] data;
    logic        write;
  } dmi_cmd_t;

  // Register map
  localparam logic [7:0] ADDR_PRCI_STATUS = 8'h00;
  localparam logic [7:0] ADDR_PRCI_SYSRST = 8'h04;
  localparam logic [7:0] ADDR_GPIO_OUT    = 8'h10;
  localparam logic [7:0] ADDR_GPIO_DIR    = 8'h14;
  localparam logic [7:0] ADDR_GPIO_IN     = 8'h18;

  // Region codes in paddr[7:4]
  localparam logic [3:0] PRCI_BASE = 4'h0;
  localparam logic [3:0] GPIO_BASE = 4'h1;

  // TAP instruction codes
  localparam logic [4:0] IR_IDCODE = 5'h01;
  localparam logic [4:0] IR_DMI    = 5'h11;
  localparam logic [4:0] IR_BYPASS = 5'h1F;

endpackage

`default_nettype wire

//--- hdl/jtag_tap.sv
`default_nettype none

module jtag_tap import chip_pkg::*; #(
  parameter logic [31:0] p_idcode = 32'h1000_0e11
) (
  input  wire logic        i_jtag_tck,
  input  wire logic        i_arst_n,
  input  wire logic        i_jtag_tms,
  input  wire logic        i_jtag_tdi,
  input  wire logic        i_dmi_ack,
  input  wire logic [31:0] i_dmi_rdata,
  output logic             o_jtag_tdo,
  output logic             o_dmi_req,
  output dmi_cmd_t         o_dmi_cmd
);

  typedef enum logic [3:0] {
    ST_TLR, ST_RTI, ST_SEL_DR, ST_CAP_DR, ST_SH_DR, ST_EX1_DR, ST_PAU_DR, ST_EX2_DR,
    ST_UPD_DR, ST_SEL_IR, ST_CAP_IR, ST_SH_IR, ST_EX1_IR, ST_PAU_IR, ST_EX2_IR, ST_UPD_IR
  } tap_state_e;

  tap_state_e  state_q;
  tap_state_e  state_d;
  logic [4:0]  ir_q;
  logic [4:0]  ir_sr;
  logic [31:0] idcode_sr;
  logic        bypass_q;
  logic [41:0] dmi_sr;
  logic        dr_tdo;
  logic [1:0]  ack_sync;
  logic [31:0] rdata_q;
  logic        busy;
  logic        start;
  dmi_op_e     scan_op;
  dmi_op_e     cap_op;

  // Standard TAP controller
  always_comb begin
    case (state_q)
      ST_TLR:    state_d = i_jtag_tms ? ST_TLR    : ST_RTI;
      ST_RTI:    state_d = i_jtag_tms ? ST_SEL_DR : ST_RTI;
      ST_SEL_DR: state_d = i_jtag_tms ? ST_SEL_IR : ST_CAP_DR;
      ST_CAP_DR: state_d = i_jtag_tms ? ST_EX1_DR : ST_SH_DR;
      ST_SH_DR:  state_d = i_jtag_tms ? ST_EX1_DR : ST_SH_DR;
      ST_EX1_DR: state_d = i_jtag_tms ? ST_UPD_DR : ST_PAU_DR;
      ST_PAU_DR: state_d = i_jtag_tms ? ST_EX2_DR : ST_PAU_DR;
      ST_EX2_DR: state_d = i_jtag_tms ? ST_UPD_DR : ST_SH_DR;
      ST_UPD_DR: state_d = i_jtag_tms ? ST_SEL_DR : ST_RTI;
      ST_SEL_IR: state_d = i_jtag_tms ? ST_TLR    : ST_CAP_IR;
      ST_CAP_IR: state_d = i_jtag_tms ? ST_EX1_IR : ST_SH_IR;
      ST_SH_IR:  state_d = i_jtag_tms ? ST_EX1_IR : ST_SH_IR;
      ST_EX1_IR: state_d = i_jtag_tms ? ST_UPD_IR : ST_PAU_IR;
      ST_PAU_IR: state_d = i_jtag_tms ? ST_EX2_IR : ST_PAU_IR;
      ST_EX2_IR: state_d = i_jtag_tms ? ST_UPD_IR : ST_SH_IR;
      default:   state_d = i_jtag_tms ? ST_SEL_DR : ST_RTI;
    endcase
  end

  always_ff @(posedge i_jtag_tck or negedge i_arst_n) begin
    if (!i_arst_n) begin
      state_q <= ST_TLR;
      ir_q    <= IR_IDCODE;
      ir_sr   <= '0;
    end else begin
      state_q <= state_d;
      case (state_q)
        ST_TLR:    ir_q  <= IR_IDCODE;
        ST_CAP_IR: ir_sr <= 5'b00001;
        ST_SH_IR:  ir_sr <= {i_jtag_tdi, ir_sr[4:1]};
        ST_UPD_IR: ir_q  <= ir_sr;
        default:   ;
      endcase
    end
  end

  // Op field of the scanned word; DMI layout is {addr, data, op}
  assign scan_op = dmi_op_e'(dmi_sr[1:0]);
  assign busy    = o_dmi_req | ack_sync[1];
  assign cap_op  = busy ? DMI_BUSY : DMI_NOP;

  // Data registers
  always_ff @(posedge i_jtag_tck) begin
    if (state_q == ST_CAP_DR) begin
      idcode_sr <= p_idcode;
      bypass_q  <= 1'b0;
      dmi_sr    <= {o_dmi_cmd.addr, rdata_q, cap_op};
    end else if (state_q == ST_SH_DR) begin
      case (ir_q)
        IR_IDCODE: idcode_sr <= {i_jtag_tdi, idcode_sr[31:1]};
        IR_DMI:    dmi_sr    <= {i_jtag_tdi, dmi_sr[41:1]};
        default:   bypass_q  <= i_jtag_tdi;
      endcase
    end
  end

  always_comb begin
    case (ir_q)
      IR_IDCODE: dr_tdo = idcode_sr[0];
      IR_DMI:    dr_tdo = dmi_sr[0];
      default:   dr_tdo = bypass_q;
    endcase
  end

  // TDO launches on the falling edge
  always_ff @(negedge i_jtag_tck or negedge i_arst_n) begin
    if (!i_arst_n) begin
      o_jtag_tdo <= 1'b0;
    end else if (state_q == ST_SH_IR) begin
      o_jtag_tdo <= ir_sr[0];
    end else if (state_q == ST_SH_DR) begin
      o_jtag_tdo <= dr_tdo;
    end else begin
      o_jtag_tdo <= 1'b0;
    end
  end

  // New request only once the previous ack has been seen low
  assign start = (state_q == ST_UPD_DR) && (ir_q == IR_DMI) && !busy &&
                 ((scan_op == DMI_READ) || (scan_op == DMI_WRITE));

  always_ff @(posedge i_jtag_tck or negedge i_arst_n) begin
    if (!i_arst_n) begin
      ack_sync  <= '0;
      o_dmi_req <= 1'b0;
      rdata_q   <= '0;
    end else begin
      ack_sync <= {ack_sync[0], i_dmi_ack};
      if (o_dmi_req && ack_sync[1]) begin
        rdata_q   <= i_dmi_rdata;
        o_dmi_req <= 1'b0;
      end else if (start) begin
        o_dmi_req <= 1'b1;
      end
    end
  end

  always_ff @(posedge i_jtag_tck) begin
    if (start) begin
      o_dmi_cmd.addr  <= dmi_sr[41:34];
      o_dmi_cmd.data  <= dmi_sr[33:2];
      o_dmi_cmd.write <= (scan_op == DMI_WRITE);
    end
  end

  // The system clock side samples cmd at any point while req is up
  a_cmd_stable: assert property (@(posedge i_jtag_tck) disable iff (!i_arst_n)
    o_dmi_req && $past(o_dmi_req) |-> $stable(o_dmi_cmd));

endmodule

`default_nettype wire

//--- hdl/dmi_bridge.sv
`default_nettype none

module dmi_bridge import chip_pkg::*; (
  input  wire logic     i_clk,
  input  wire logic     i_arst_n,
  input  wire logic     i_dmi_req,
  input  wire dmi_cmd_t i_dmi_cmd,
  input  wire apb_rsp_t i_prci_rsp,
  input  wire apb_rsp_t i_gpio_rsp,
  output logic          o_dmi_ack,
  output logic [31:0]   o_dmi_rdata,
  output apb_req_t      o_apb_req,
  output logic          o_prci_psel,
  output logic          o_gpio_psel
);

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_SETUP,
    ST_ACCESS,
    ST_LATCH,
    ST_DONE
  } br_state_e;

  br_state_e state_q;
  logic [1:0] req_sync;
  dmi_cmd_t   cmd_q;
  logic       in_xfer;
  logic       sel_prci;
  logic       sel_gpio;
  logic       psel_any;

  // Region decode from the upper nibble
  assign sel_prci = (cmd_q.addr[7:4] == PRCI_BASE);
  assign sel_gpio = (cmd_q.addr[7:4] == GPIO_BASE);

  assign in_xfer     = (state_q == ST_SETUP) || (state_q == ST_ACCESS);
  assign o_prci_psel = in_xfer && sel_prci;
  assign o_gpio_psel = in_xfer && sel_gpio;
  assign psel_any    = o_prci_psel | o_gpio_psel;

  // Unmapped addresses get no enable either
  assign o_apb_req.paddr   = cmd_q.addr;
  assign o_apb_req.pwrite  = cmd_q.write;
  assign o_apb_req.pwdata  = cmd_q.data;
  assign o_apb_req.penable = (state_q == ST_ACCESS) && psel_any;

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      req_sync  <= '0;
      state_q   <= ST_IDLE;
      o_dmi_ack <= 1'b0;
    end else begin
      req_sync <= {req_sync[0], i_dmi_req};
      case (state_q)
        ST_IDLE:   if (req_sync[1]) state_q <= ST_SETUP;
        ST_SETUP:  state_q <= ST_ACCESS;
        ST_ACCESS: state_q <= ST_LATCH;
        ST_LATCH: begin
          o_dmi_ack <= 1'b1;
          state_q   <= ST_DONE;
        end
        // Hold ack until the TAP drops req
        ST_DONE: begin
          if (!req_sync[1]) begin
            o_dmi_ack <= 1'b0;
            state_q   <= ST_IDLE;
          end
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  // cmd is held stable by the TAP while req is up
  always_ff @(posedge i_clk) begin
    if (state_q == ST_IDLE && req_sync[1]) begin
      cmd_q <= i_dmi_cmd;
    end
    if (state_q == ST_ACCESS) begin
      if (sel_prci) o_dmi_rdata <= i_prci_rsp.prdata;
      else if (sel_gpio) o_dmi_rdata <= i_gpio_rsp.prdata;
      else o_dmi_rdata <= '0;
    end
  end

  a_ack_after_req: assert property (@(posedge i_clk) disable iff (!i_arst_n)
    $rose(o_dmi_ack) |-> req_sync[1]);

  a_penable_after_psel: assert property (@(posedge i_clk) disable iff (!i_arst_n)
    o_apb_req.penable |-> $past(psel_any) && !$past(o_apb_req.penable) && psel_any);

endmodule

`default_nettype wire

//--- hdl/prci.sv
`default_nettype none

module prci import chip_pkg::*; #(
  parameter int p_sysrst_cycles = 16,
  parameter int p_lock_cycles   = 8
) (
  input  wire logic     i_clk,
  input  wire logic     i_arst_n,
  input  wire apb_req_t i_apb_req,
  input  wire logic     i_psel,
  output apb_rsp_t      o_apb_rsp,
  output logic          o_dbg_nrst,
  output logic          o_sys_nrst
);

  localparam int SYS_W  = $clog2(p_sysrst_cycles + 1);
  localparam int LOCK_W = $clog2(p_lock_cycles + 1);

  logic [1:0]        dbg_sync;
  logic [SYS_W-1:0]  sysrst_cnt;
  logic [LOCK_W-1:0] lock_cnt;
  logic              pll_lock;
  logic              dbg_rst_flag;
  logic              wr_sysrst;

  // Power reset synchronized into the debug domain
  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      dbg_sync <= '0;
    end else begin
      dbg_sync <= {dbg_sync[0], 1'b1};
    end
  end

  assign o_dbg_nrst = dbg_sync[1];

  // Stand-in for the PLL lock indicator
  assign pll_lock = (lock_cnt == LOCK_W'(p_lock_cycles));

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      lock_cnt <= '0;
    end else if (!pll_lock) begin
      lock_cnt <= lock_cnt + 1'b1;
    end
  end

  assign wr_sysrst = i_psel && i_apb_req.penable && i_apb_req.pwrite &&
                     (i_apb_req.paddr == ADDR_PRCI_SYSRST) && i_apb_req.pwdata[0];

  // System reset follows the debug release unless a debug pulse is running
  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      o_sys_nrst   <= 1'b0;
      sysrst_cnt   <= '0;
      dbg_rst_flag <= 1'b0;
    end else if (wr_sysrst) begin
      o_sys_nrst   <= 1'b0;
      sysrst_cnt   <= SYS_W'(p_sysrst_cycles - 1);
      dbg_rst_flag <= 1'b1;
    end else if (sysrst_cnt != '0) begin
      sysrst_cnt <= sysrst_cnt - 1'b1;
    end else begin
      o_sys_nrst <= dbg_sync[0];
    end
  end

  always_comb begin
    o_apb_rsp = '0;
    if (i_apb_req.paddr == ADDR_PRCI_STATUS) begin
      o_apb_rsp.prdata = {30'b0, dbg_rst_flag, pll_lock};
    end
  end

  // System domain stays in reset while the debug domain is held
  a_sys_under_dbg: assert property (@(posedge i_clk)
    !o_dbg_nrst |-> !o_sys_nrst);

endmodule

`default_nettype wire

//--- hdl/apb_gpio.sv
`default_nettype none

module apb_gpio import chip_pkg::*; (
  input  wire logic              i_clk,
  input  wire logic              i_sys_nrst,
  input  wire apb_req_t          i_apb_req,
  input  wire logic              i_psel,
  input  wire logic [GPIO_W-1:0] i_gpio,
  output apb_rsp_t               o_apb_rsp,
  output logic [GPIO_W-1:0]      o_gpio,
  output logic [GPIO_W-1:0]      o_gpio_oe
);

  logic [GPIO_W-1:0] out_q;
  logic [GPIO_W-1:0] dir_q;
  logic [GPIO_W-1:0] in_meta;
  logic [GPIO_W-1:0] in_sync;
  logic              wr_en;

  assign wr_en = i_psel && i_apb_req.penable && i_apb_req.pwrite;

  always_ff @(posedge i_clk or negedge i_sys_nrst) begin
    if (!i_sys_nrst) begin
      out_q <= '0;
      dir_q <= '0;
    end else if (wr_en) begin
      case (i_apb_req.paddr)
        ADDR_GPIO_OUT: out_q <= i_apb_req.pwdata[GPIO_W-1:0];
        ADDR_GPIO_DIR: dir_q <= i_apb_req.pwdata[GPIO_W-1:0];
        default:       ;
      endcase
    end
  end

  // Pins are asynchronous to i_clk
  always_ff @(posedge i_clk) begin
    in_meta <= i_gpio;
    in_sync <= in_meta;
  end

  always_comb begin
    o_apb_rsp = '0;
    case (i_apb_req.paddr)
      ADDR_GPIO_OUT: o_apb_rsp.prdata = 32'(out_q);
      ADDR_GPIO_DIR: o_apb_rsp.prdata = 32'(dir_q);
      ADDR_GPIO_IN:  o_apb_rsp.prdata = 32'(in_sync);
      default:       o_apb_rsp.prdata = '0;
    endcase
  end

  assign o_gpio    = out_q;
  assign o_gpio_oe = dir_q;

endmodule

`default_nettype wire

//--- hdl/chip_top.sv
`default_nettype none

module chip_top import chip_pkg::*; #(
  parameter logic [31:0] p_idcode        = 32'h1000_0e11,
  parameter int          p_sysrst_cycles = 16,
  parameter int          p_lock_cycles   = 8
) (
  input  wire logic              i_clk,
  input  wire logic              i_arst_n,
  input  wire logic              i_jtag_tck,
  input  wire logic              i_jtag_tms,
  input  wire logic              i_jtag_tdi,
  input  wire logic [GPIO_W-1:0] i_gpio,
  output logic                   o_jtag_tdo,
  output logic [GPIO_W-1:0]      o_gpio,
  output logic [GPIO_W-1:0]      o_gpio_oe
);

  logic        dmi_req;
  logic        dmi_ack;
  dmi_cmd_t    dmi_cmd;
  logic [31:0] dmi_rdata;
  apb_req_t    apb_req;
  apb_rsp_t    prci_rsp;
  apb_rsp_t    gpio_rsp;
  logic        prci_psel;
  logic        gpio_psel;
  logic        dbg_nrst;
  logic        sys_nrst;

  jtag_tap #(
    .p_idcode(p_idcode)
  ) u_tap (
    .i_jtag_tck (i_jtag_tck),
    .i_arst_n   (i_arst_n),
    .i_jtag_tms (i_jtag_tms),
    .i_jtag_tdi (i_jtag_tdi),
    .i_dmi_ack  (dmi_ack),
    .i_dmi_rdata(dmi_rdata),
    .o_jtag_tdo (o_jtag_tdo),
    .o_dmi_req  (dmi_req),
    .o_dmi_cmd  (dmi_cmd)
  );

  // Bridge sits in the debug reset domain
  dmi_bridge u_bridge (
    .i_clk      (i_clk),
    .i_arst_n   (dbg_nrst),
    .i_dmi_req  (dmi_req),
    .i_dmi_cmd  (dmi_cmd),
    .i_prci_rsp (prci_rsp),
    .i_gpio_rsp (gpio_rsp),
    .o_dmi_ack  (dmi_ack),
    .o_dmi_rdata(dmi_rdata),
    .o_apb_req  (apb_req),
    .o_prci_psel(prci_psel),
    .o_gpio_psel(gpio_psel)
  );

  prci #(
    .p_sysrst_cycles(p_sysrst_cycles),
    .p_lock_cycles  (p_lock_cycles)
  ) u_prci (
    .i_clk     (i_clk),
    .i_arst_n  (i_arst_n),
    .i_apb_req (apb_req),
    .i_psel    (prci_psel),
    .o_apb_rsp (prci_rsp),
    .o_dbg_nrst(dbg_nrst),
    .o_sys_nrst(sys_nrst)
  );

  apb_gpio u_gpio (
    .i_clk     (i_clk),
    .i_sys_nrst(sys_nrst),
    .i_apb_req (apb_req),
    .i_psel    (gpio_psel),
    .i_gpio    (i_gpio),
    .o_apb_rsp (gpio_rsp),
    .o_gpio    (o_gpio),
    .o_gpio_oe (o_gpio_oe)
  );

endmodule

`default_nettype wire

//--- verif/tb_jtag_tasks.svh
`ifndef TB_JTAG_TASKS_SVH
`define TB_JTAG_TASKS_SVH

// DMI scan word is {addr[7:0], data[31:0], op[1:0]}
localparam int DMI_W     = 42;
localparam int MAX_POLLS = 8;

// One TCK period: three i_clk edges low, then three high
// TDO is sampled just before the rising edge
task automatic jtag_clock(input logic tms, input logic tdi, output logic tdo);
  @(posedge i_clk);
  i_jtag_tck <= 1'b0;
  i_jtag_tms <= tms;
  i_jtag_tdi <= tdi;
  repeat (3) @(posedge i_clk);
  tdo = o_jtag_tdo;
  i_jtag_tck <= 1'b1;
  repeat (2) @(posedge i_clk);
endtask

// Five TMS-high clocks reach Test-Logic-Reset, one more lands in idle
task automatic tap_reset();
  logic tdo_bit;
  repeat (5) jtag_clock(1'b1, 1'b0, tdo_bit);
  jtag_clock(1'b0, 1'b0, tdo_bit);
endtask

task automatic scan_ir(input logic [4:0] ir);
  logic tdo_bit;
  // Idle to Select-DR, Select-IR, Capture-IR, Shift-IR
  jtag_clock(1'b1, 1'b0, tdo_bit);
  jtag_clock(1'b1, 1'b0, tdo_bit);
  jtag_clock(1'b0, 1'b0, tdo_bit);
  jtag_clock(1'b0, 1'b0, tdo_bit);
  for (int i = 0; i < 5; i++) begin
    jtag_clock(i == 4, ir[i], tdo_bit);
  end
  jtag_clock(1'b1, 1'b0, tdo_bit);
  jtag_clock(1'b0, 1'b0, tdo_bit);
endtask

// LSB first, dout[i] is the TDO bit seen while din[i] is shifted in
task automatic scan_dr(input int width, input logic [63:0] din, output logic [63:0] dout);
  logic tdo_bit;
  dout = '0;
  jtag_clock(1'b1, 1'b0, tdo_bit);
  jtag_clock(1'b0, 1'b0, tdo_bit);
  jtag_clock(1'b0, 1'b0, tdo_bit);
  for (int i = 0; i < width; i++) begin
    jtag_clock(i == width - 1, din[i], tdo_bit);
    dout[i] = tdo_bit;
  end
  // Update-DR launches the request, then back to idle
  jtag_clock(1'b1, 1'b0, tdo_bit);
  jtag_clock(1'b0, 1'b0, tdo_bit);
endtask

// NOP scans until capture no longer reports a busy transfer
task automatic dmi_poll(output logic [31:0] rdata);
  logic [63:0] dout;
  int          tries;
  tries = 0;
  dout  = '0;
  do begin
    scan_dr(DMI_W, 64'h0, dout);
    tries++;
  end while (dout[1:0] != DMI_NOP && tries < MAX_POLLS);
  if (dout[1:0] != DMI_NOP) begin
    $display("DMI transfer still busy after %0d polling scans", tries);
    abort_run();
  end else begin
    rdata = dout[33:2];
  end
endtask

task automatic dmi_write(input logic [7:0] addr, input logic [31:0] data);
  logic [63:0] dout;
  logic [31:0] rdata;
  scan_dr(DMI_W, {22'b0, addr, data, DMI_WRITE}, dout);
  dmi_poll(rdata);
endtask

task automatic dmi_read(input logic [7:0] addr, output logic [31:0] data);
  logic [63:0] dout;
  scan_dr(DMI_W, {22'b0, addr, 32'h0, DMI_READ}, dout);
  dmi_poll(data);
endtask

`endif

//--- verif/tb_chip_top.sv
`default_nettype none

module tb_chip_top import chip_pkg::*; ();
  timeunit 1ns;
  timeprecision 1ps;

  localparam logic [31:0] IDCODE        = 32'h2b9a_51c7;
  localparam int          SYSRST_CYCLES = 16;
  localparam int          LOCK_CYCLES   = 8;
  localparam logic [31:0] SEED          = 32'hf923;
  localparam logic [7:0]  ADDR_UNMAPPED = 8'h30;

  localparam int CLK_NS  = 20;
  localparam int TCK_NS  = 6 * CLK_NS;
  // IR scans and plain DR scans in the sequence
  localparam int N_PLAIN_SCANS = 7;
  // Each DMI access is one command scan and two polls
  localparam int N_DMI_ACCESS  = 29;
  localparam int N_SCANS       = N_PLAIN_SCANS + 3 * N_DMI_ACCESS;
  localparam int WATCHDOG_NS   = N_SCANS * 60 * TCK_NS * 2;

  logic              i_clk;
  logic              i_arst_n;
  logic              i_jtag_tck;
  logic              i_jtag_tms;
  logic              i_jtag_tdi;
  logic [GPIO_W-1:0] i_gpio;
  logic              o_jtag_tdo;
  logic [GPIO_W-1:0] o_gpio;
  logic [GPIO_W-1:0] o_gpio_oe;
  logic [GPIO_W-1:0] pin_val;

  chip_top #(
    .p_idcode       (IDCODE),
    .p_sysrst_cycles(SYSRST_CYCLES),
    .p_lock_cycles  (LOCK_CYCLES)
  ) u_dut (
    .i_clk     (i_clk),
    .i_arst_n  (i_arst_n),
    .i_jtag_tck(i_jtag_tck),
    .i_jtag_tms(i_jtag_tms),
    .i_jtag_tdi(i_jtag_tdi),
    .i_gpio    (i_gpio),
    .o_jtag_tdo(o_jtag_tdo),
    .o_gpio    (o_gpio),
    .o_gpio_oe (o_gpio_oe)
  );

  initial begin
    i_clk = 1'b0;
    forever #(CLK_NS / 2) i_clk = ~i_clk;
  end

  // Pins follow the chip where it drives them and the bench value elsewhere
  initial begin
    i_gpio <= '0;
    forever begin
      @(posedge i_clk);
      i_gpio <= (o_gpio & o_gpio_oe) | (pin_val & ~o_gpio_oe);
    end
  end

  task automatic abort_run();
    $display("tests failed");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic check_eq(input string name, input logic [31:0] expected,
                          input logic [31:0] actual);
    assert (actual === expected)
    else begin
      $display("CHECK FAILED time %0t %s expected 0x%08h actual 0x%08h",
               $time, name, expected, actual);
      abort_run();
    end
  endtask

  task automatic report_oe_error();
    $display("CHECK FAILED time %0t o_gpio_oe expected 0x%03h actual 0x%03h",
             $time, {GPIO_W{1'b0}}, o_gpio_oe);
    abort_run();
  endtask

  function automatic logic [GPIO_W-1:0] rand_gpio();
    logic [31:0] r;
    r = $urandom();
    return r[GPIO_W-1:0];
  endfunction

  `include "tb_jtag_tasks.svh"

  // No pin is driven right at and just after a system reset release
  a_oe_at_release: assert property (@(posedge i_clk) disable iff (!i_arst_n)
    $rose(u_dut.sys_nrst) |-> o_gpio_oe == '0)
    else report_oe_error();

  a_oe_after_release: assert property (@(posedge i_clk) disable iff (!i_arst_n)
    $rose(u_dut.sys_nrst) |=> o_gpio_oe == '0)
    else report_oe_error();

  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog expired after %0d ns, the JTAG or DMI sequence hung", WATCHDOG_NS);
    abort_run();
  end

  initial begin
    logic [63:0]       dout;
    logic [31:0]       rd;
    logic [31:0]       r32;
    logic [GPIO_W-1:0] out_v;
    logic [GPIO_W-1:0] dir_v;
    logic [GPIO_W-1:0] pins_v;
    logic [GPIO_W-1:0] exp_in;
    void'($urandom(SEED));
    i_arst_n   <= 1'b0;
    i_jtag_tck <= 1'b0;
    i_jtag_tms <= 1'b1;
    i_jtag_tdi <= 1'b0;
    pin_val    <= '0;
    repeat (5) @(posedge i_clk);
    i_arst_n <= 1'b1;
    repeat (4) @(posedge i_clk);

    // IDCODE is the default instruction after TAP reset
    tap_reset();
    scan_dr(32, 64'h0, dout);
    check_eq("idcode", IDCODE, dout[31:0]);

    // Bypass delays TDI by one TCK and captures a zero
    scan_ir(IR_BYPASS);
    r32 = $urandom();
    scan_dr(17, {48'b0, r32[15:0]}, dout);
    check_eq("bypass tdo", {15'h0, r32[15:0], 1'b0}, {15'h0, dout[16:0]});

    scan_ir(IR_DMI);
    for (int n = 0; n < 3; n++) begin
      out_v = rand_gpio();
      dir_v = rand_gpio();
      dmi_write(ADDR_GPIO_OUT, 32'(out_v));
      dmi_write(ADDR_GPIO_DIR, 32'(dir_v));
      check_eq("o_gpio", 32'(out_v), 32'(o_gpio));
      check_eq("o_gpio_oe", 32'(dir_v), 32'(o_gpio_oe));
      dmi_read(ADDR_GPIO_OUT, rd);
      check_eq("gpio out", 32'(out_v), rd);
      dmi_read(ADDR_GPIO_DIR, rd);
      check_eq("gpio dir", 32'(dir_v), rd);
    end

    // Input register sees the pins as the model drives them
    for (int n = 0; n < 2; n++) begin
      pins_v = rand_gpio();
      pin_val <= pins_v;
      exp_in = (out_v & dir_v) | (pins_v & ~dir_v);
      dmi_read(ADDR_GPIO_IN, rd);
      check_eq("gpio in", 32'(exp_in), rd);
    end

    // Debug-requested system reset
    dmi_read(ADDR_PRCI_STATUS, rd);
    check_eq("prci status before sysrst", 32'h1, rd);
    dmi_write(ADDR_PRCI_SYSRST, 32'h1);
    dmi_read(ADDR_GPIO_OUT, rd);
    check_eq("gpio out after sysrst", 32'h0, rd);
    dmi_read(ADDR_GPIO_DIR, rd);
    check_eq("gpio dir after sysrst", 32'h0, rd);
    check_eq("o_gpio_oe after sysrst", 32'h0, 32'(o_gpio_oe));
    dmi_read(ADDR_PRCI_STATUS, rd);
    check_eq("prci status after sysrst", 32'h3, rd);
    scan_ir(IR_IDCODE);
    scan_dr(32, 64'h0, dout);
    check_eq("idcode after sysrst", IDCODE, dout[31:0]);
    scan_ir(IR_DMI);
    dmi_read(ADDR_PRCI_STATUS, rd);
    check_eq("prci status via dmi after idcode", 32'h3, rd);

    // Region 0x3 decodes to no slave
    out_v = rand_gpio();
    out_v[0] = 1'b1;
    dir_v = rand_gpio();
    dir_v[0] = 1'b1;
    dmi_write(ADDR_GPIO_OUT, 32'(out_v));
    dmi_write(ADDR_GPIO_DIR, 32'(dir_v));
    // Leaves nonzero read data in the bridge ahead of the unmapped read
    dmi_read(ADDR_GPIO_OUT, rd);
    check_eq("gpio out before unmapped read", 32'(out_v), rd);
    dmi_read(ADDR_UNMAPPED, rd);
    check_eq("unmapped read", 32'h0, rd);
    dmi_write(ADDR_UNMAPPED, 32'hffff_ffff);
    dmi_write(ADDR_UNMAPPED | ADDR_PRCI_SYSRST, 32'h1);
    dmi_read(ADDR_GPIO_OUT, rd);
    check_eq("gpio out after unmapped writes", 32'(out_v), rd);
    dmi_read(ADDR_GPIO_DIR, rd);
    check_eq("gpio dir after unmapped writes", 32'(dir_v), rd);
    dmi_read(ADDR_PRCI_STATUS, rd);
    check_eq("prci status after unmapped writes", 32'h3, rd);
    check_eq("o_gpio after unmapped writes", 32'(out_v), 32'(o_gpio));
    check_eq("o_gpio_oe after unmapped writes", 32'(dir_v), 32'(o_gpio_oe));

    $display("all tests passed");
    $finish;
  end

endmodule

`default_nettype wire

//--- build.f
+incdir+verif
hdl/chip_pkg.sv
hdl/jtag_tap.sv
hdl/dmi_bridge.sv
hdl/prci.sv
hdl/apb_gpio.sv
hdl/chip_top.sv
verif/tb_chip_top.sv

//--- Makefile
SIM := obj_dir/Vtb_chip_top

all: run

$(SIM): build.f $(wildcard hdl/*.sv) $(wildcard verif/*.sv) $(wildcard verif/*.svh)
	verilator --binary --timing --assert --timescale 1ns/1ps \
	  --top-module tb_chip_top -Mdir obj_dir -f build.f

run: $(SIM)
	@out="$$(./$(SIM))"; \
	  echo "$$out"; \
	  echo "$$out" | grep -qx "all tests passed"

clean:
	rm -rf obj_dir

.PHONY: all run clean
